// File: include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file size
`define CORE_XLEN 32
`define CORE_NR_REGS 32

// Fixed program counter targets
`define CORE_BOOT_ADDR 32'h0
`define CORE_TRAP_VECTOR 32'h100

// Counter addresses readable with CSRRS
`define CORE_CSR_INSTRET 12'hB02
`define CORE_CSR_BRTAKEN 12'hB03

`endif

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 and funct7 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // ----------------------------------------------------------
  // Instruction formats, MSB first
  // ----------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // One word, four views
  typedef union packed {
    r_type_t r;
    i_type_t i;
    b_type_t b;
    u_type_t u;
  } instr_t;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

  `include "core_cfg.svh"

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_BEQ,
    ALU_BNE,
    ALU_CSR
  } alu_op_e;

  // ----------------------------------------------------------
  // Stage records
  // ----------------------------------------------------------
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    isa_pkg::instr_t       instr;
  } fetch_entry_t;

  // Operand b already holds the immediate for I and U formats
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    alu_op_e               alu_op;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] operand_a;
    logic [`CORE_XLEN-1:0] operand_b;
    logic [`CORE_XLEN-1:0] imm;
    logic [11:0]           csr_addr;
    logic                  illegal;
    isa_pkg::instr_t       instr;
  } decoded_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] result;
    logic                  is_csr;
    logic [11:0]           csr_addr;
    logic                  illegal;
    isa_pkg::instr_t       instr;
    logic                  branch_taken;
  } exec_result_t;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
  } redirect_t;

  // One record per retired instruction
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] wdata;
    logic                  exception;
    logic [`CORE_XLEN-1:0] tval;
  } commit_trace_t;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`default_nettype none

`include "core_cfg.svh"

module fetch_stage (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  stall_i,
  input  wire core_pkg::redirect_t   redirect_i,
  input  wire logic                  flush_i,
  output logic [`CORE_XLEN-1:0]      imem_addr_o,
  input  wire logic [`CORE_XLEN-1:0] imem_rdata_i,
  output core_pkg::fetch_entry_t     fetch_entry_o
);

  logic [`CORE_XLEN-1:0] pc_q;
  core_pkg::fetch_entry_t entry_q;

  // Redirect wins over a stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= `CORE_BOOT_ADDR;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.pc;
    end else if (!stall_i) begin
      pc_q <= pc_q + `CORE_XLEN'd4;
    end
  end

  // Word arrives in the same cycle as its address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
    end else if (flush_i) begin
      entry_q <= '0;
    end else if (!stall_i) begin
      entry_q.valid <= 1'b1;
      entry_q.pc    <= pc_q;
      entry_q.instr <= imem_rdata_i;
    end
  end

  assign imem_addr_o   = pc_q;
  assign fetch_entry_o = entry_q;

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire core_pkg::fetch_entry_t fetch_entry_i,
  input  wire logic                  flush_i,
  input  wire logic [4:0]            ex_busy_rd_i,
  input  wire logic                  ex_busy_i,
  input  wire logic [4:0]            cm_busy_rd_i,
  input  wire logic                  cm_busy_i,
  input  wire logic                  rf_we_i,
  input  wire logic [4:0]            rf_waddr_i,
  input  wire logic [`CORE_XLEN-1:0] rf_wdata_i,
  output logic                       stall_o,
  output core_pkg::decoded_t         decoded_o
);

  isa_pkg::instr_t       instr;
  core_pkg::alu_op_e     alu_op;
  logic [4:0]            rd;
  logic [`CORE_XLEN-1:0] imm;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  use_imm;
  logic                  illegal;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic                  raw_ex;
  logic                  raw_cm;

  // x0 is not stored
  logic [`CORE_XLEN-1:0] regs_q [1:`CORE_NR_REGS-1];

  assign instr = fetch_entry_i.instr;

  // ----------------------------------------------------------
  // Decoder
  // ----------------------------------------------------------
  always_comb begin
    alu_op  = core_pkg::ALU_ADD;
    rd      = instr.r.rd;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (instr.r.opcode)
      isa_pkg::OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB}: alu_op = core_pkg::ALU_ADD;
          {isa_pkg::F7_SUB, isa_pkg::F3_ADD_SUB}:  alu_op = core_pkg::ALU_SUB;
          {isa_pkg::F7_BASE, isa_pkg::F3_XOR}:     alu_op = core_pkg::ALU_XOR;
          {isa_pkg::F7_BASE, isa_pkg::F3_OR}:      alu_op = core_pkg::ALU_OR;
          {isa_pkg::F7_BASE, isa_pkg::F3_AND}:     alu_op = core_pkg::ALU_AND;
          default:                                 illegal = 1'b1;
        endcase
      end
      isa_pkg::OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        imm     = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        case (instr.i.funct3)
          isa_pkg::F3_ADD_SUB: alu_op = core_pkg::ALU_ADD;
          isa_pkg::F3_XOR:     alu_op = core_pkg::ALU_XOR;
          isa_pkg::F3_OR:      alu_op = core_pkg::ALU_OR;
          isa_pkg::F3_AND:     alu_op = core_pkg::ALU_AND;
          default:             illegal = 1'b1;
        endcase
      end
      isa_pkg::OPC_LUI: begin
        alu_op  = core_pkg::ALU_PASS_B;
        use_imm = 1'b1;
        imm     = {instr.u.imm, 12'b0};
      end
      isa_pkg::OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        rd      = '0;
        imm     = {{(`CORE_XLEN-12){instr.b.imm12}}, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
        case (instr.b.funct3)
          isa_pkg::F3_BEQ: alu_op = core_pkg::ALU_BEQ;
          isa_pkg::F3_BNE: alu_op = core_pkg::ALU_BNE;
          default:         illegal = 1'b1;
        endcase
      end
      isa_pkg::OPC_SYSTEM: begin
        // Only counter reads as CSRRS with rs1 = x0
        alu_op = core_pkg::ALU_CSR;
        if (instr.i.funct3 != isa_pkg::F3_CSRRS || instr.i.rs1 != '0) begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      rd      = '0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  // ----------------------------------------------------------
  // Register file and interlock
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `CORE_NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rf_we_i && rf_waddr_i != '0) begin
      regs_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

  assign rs1_data = (instr.r.rs1 == '0) ? '0 : regs_q[instr.r.rs1];
  assign rs2_data = (instr.r.rs2 == '0) ? '0 : regs_q[instr.r.rs2];

  // Without forwarding a reader waits until the producer has written back
  assign raw_ex = ex_busy_i && ex_busy_rd_i != '0 &&
                  ((use_rs1 && instr.r.rs1 == ex_busy_rd_i) ||
                   (use_rs2 && instr.r.rs2 == ex_busy_rd_i));
  assign raw_cm = cm_busy_i && cm_busy_rd_i != '0 &&
                  ((use_rs1 && instr.r.rs1 == cm_busy_rd_i) ||
                   (use_rs2 && instr.r.rs2 == cm_busy_rd_i));

  assign stall_o = fetch_entry_i.valid && (raw_ex || raw_cm);

  always_comb begin
    decoded_o.valid     = fetch_entry_i.valid && !stall_o && !flush_i;
    decoded_o.pc        = fetch_entry_i.pc;
    decoded_o.alu_op    = alu_op;
    decoded_o.rd        = rd;
    decoded_o.operand_a = rs1_data;
    decoded_o.operand_b = use_imm ? imm : rs2_data;
    decoded_o.imm       = imm;
    decoded_o.csr_addr  = instr.i.imm;
    decoded_o.illegal   = illegal;
    decoded_o.instr     = instr;
  end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none

`include "core_cfg.svh"

module execute_stage (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire core_pkg::decoded_t decoded_i,
  input  wire logic               flush_i,
  output logic [4:0]              busy_rd_o,
  output logic                    busy_o,
  output core_pkg::redirect_t     branch_redirect_o,
  output core_pkg::exec_result_t  result_o
);

  core_pkg::decoded_t    ex_q;
  logic [`CORE_XLEN-1:0] alu_res;
  logic                  taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_q <= '0;
    end else if (flush_i) begin
      ex_q <= '0;
    end else begin
      ex_q <= decoded_i;
    end
  end

  // ----------------------------------------------------------
  // ALU and branch condition
  // ----------------------------------------------------------
  always_comb begin
    alu_res = '0;
    taken   = 1'b0;
    case (ex_q.alu_op)
      core_pkg::ALU_ADD:    alu_res = ex_q.operand_a + ex_q.operand_b;
      core_pkg::ALU_SUB:    alu_res = ex_q.operand_a - ex_q.operand_b;
      core_pkg::ALU_AND:    alu_res = ex_q.operand_a & ex_q.operand_b;
      core_pkg::ALU_OR:     alu_res = ex_q.operand_a | ex_q.operand_b;
      core_pkg::ALU_XOR:    alu_res = ex_q.operand_a ^ ex_q.operand_b;
      core_pkg::ALU_PASS_B: alu_res = ex_q.operand_b;
      core_pkg::ALU_BEQ:    taken = (ex_q.operand_a == ex_q.operand_b);
      core_pkg::ALU_BNE:    taken = (ex_q.operand_a != ex_q.operand_b);
      // Counter value is filled in at commit
      default:              alu_res = '0;
    endcase
  end

  // Only a taken branch redirects under not-taken prediction
  assign branch_redirect_o.valid = ex_q.valid && taken;
  assign branch_redirect_o.pc    = ex_q.pc + ex_q.imm;

  assign busy_o    = ex_q.valid;
  assign busy_rd_o = ex_q.rd;

  always_comb begin
    result_o.valid        = ex_q.valid && !flush_i;
    result_o.pc           = ex_q.pc;
    result_o.rd           = ex_q.rd;
    result_o.result       = alu_res;
    result_o.is_csr       = (ex_q.alu_op == core_pkg::ALU_CSR);
    result_o.csr_addr     = ex_q.csr_addr;
    result_o.illegal      = ex_q.illegal;
    result_o.instr        = ex_q.instr;
    result_o.branch_taken = taken;
  end

endmodule

`default_nettype wire

// File: hw/commit_stage.sv
`default_nettype none

`include "core_cfg.svh"

module commit_stage (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire core_pkg::exec_result_t result_i,
  input  wire logic [`CORE_XLEN-1:0]  count_value_i,
  output logic [11:0]                 csr_addr_o,
  output logic                        retire_o,
  output logic                        br_taken_o,
  output logic                        rf_we_o,
  output logic [4:0]                  rf_waddr_o,
  output logic [`CORE_XLEN-1:0]       rf_wdata_o,
  output logic [4:0]                  busy_rd_o,
  output logic                        busy_o,
  output core_pkg::redirect_t         trap_redirect_o,
  output core_pkg::commit_trace_t     commit_trace_o
);

  core_pkg::exec_result_t cm_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cm_q <= '0;
    end else begin
      cm_q <= result_i;
    end
  end

  assign csr_addr_o = cm_q.csr_addr;
  assign rf_wdata_o = cm_q.is_csr ? count_value_i : cm_q.result;
  assign rf_waddr_o = cm_q.rd;
  assign rf_we_o    = cm_q.valid && !cm_q.illegal && cm_q.rd != '0;

  assign retire_o   = cm_q.valid && !cm_q.illegal;
  assign br_taken_o = cm_q.valid && cm_q.branch_taken;

  assign busy_o    = cm_q.valid;
  assign busy_rd_o = cm_q.rd;

  assign trap_redirect_o.valid = cm_q.valid && cm_q.illegal;
  assign trap_redirect_o.pc    = `CORE_TRAP_VECTOR;

  // rd and wdata show up only for a real register write
  always_comb begin
    commit_trace_o.valid     = cm_q.valid;
    commit_trace_o.pc        = cm_q.pc;
    commit_trace_o.rd        = rf_we_o ? cm_q.rd : '0;
    commit_trace_o.wdata     = rf_we_o ? rf_wdata_o : '0;
    commit_trace_o.exception = cm_q.illegal;
    commit_trace_o.tval      = cm_q.illegal ? cm_q.instr : '0;
  end

endmodule

`default_nettype wire

// File: hw/pipeline_ctrl.sv
`default_nettype none

module pipeline_ctrl (
  input  wire core_pkg::redirect_t branch_redirect_i,
  input  wire core_pkg::redirect_t trap_redirect_i,
  output core_pkg::redirect_t      redirect_o,
  output logic                     flush_front_o,
  output logic                     flush_ex_o
);

  // Trapping instruction sits in commit and is older than any branch
  always_comb begin
    if (trap_redirect_i.valid) begin
      redirect_o = trap_redirect_i;
    end else begin
      redirect_o = branch_redirect_i;
    end
  end

  assign flush_front_o = trap_redirect_i.valid || branch_redirect_i.valid;

  // Execute entry is only wrong-path on a trap
  assign flush_ex_o = trap_redirect_i.valid;

endmodule

`default_nettype wire

// File: hw/perf_counters.sv
`default_nettype none

`include "core_cfg.svh"

module perf_counters (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        retire_i,
  input  wire logic        br_taken_i,
  input  wire logic [11:0] csr_addr_i,
  output logic [`CORE_XLEN-1:0] count_value_o
);

  logic [`CORE_XLEN-1:0] instret_q;
  logic [`CORE_XLEN-1:0] brtaken_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_q <= '0;
      brtaken_q <= '0;
    end else begin
      if (retire_i) begin
        instret_q <= instret_q + 1'b1;
      end
      if (br_taken_i) begin
        brtaken_q <= brtaken_q + 1'b1;
      end
    end
  end

  // Read sees the count before the reading instruction
  always_comb begin
    case (csr_addr_i)
      `CORE_CSR_INSTRET: count_value_o = instret_q;
      `CORE_CSR_BRTAKEN: count_value_o = brtaken_q;
      default:           count_value_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/tiny_core.sv
`default_nettype none

`include "core_cfg.svh"

module tiny_core (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  output logic [`CORE_XLEN-1:0]      imem_addr_o,
  input  wire logic [`CORE_XLEN-1:0] imem_rdata_i,
  output core_pkg::commit_trace_t    commit_trace_o
);

  // ----------------------------------------------------------
  // Stage to stage
  // ----------------------------------------------------------
  core_pkg::fetch_entry_t fetch_entry;
  core_pkg::decoded_t     decoded;
  core_pkg::exec_result_t exec_result;
  logic                   stall;

  // Interlock and write-back
  logic [4:0]            ex_busy_rd;
  logic                  ex_busy;
  logic [4:0]            cm_busy_rd;
  logic                  cm_busy;
  logic                  rf_we;
  logic [4:0]            rf_waddr;
  logic [`CORE_XLEN-1:0] rf_wdata;

  // Control and counters
  core_pkg::redirect_t   branch_redirect;
  core_pkg::redirect_t   trap_redirect;
  core_pkg::redirect_t   redirect;
  logic                  flush_front;
  logic                  flush_ex;
  logic [11:0]           csr_addr;
  logic [`CORE_XLEN-1:0] count_value;
  logic                  retire;
  logic                  br_taken;

  fetch_stage u_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .flush_i       (flush_front),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .fetch_entry_o (fetch_entry)
  );

  decode_stage u_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_entry_i (fetch_entry),
    .flush_i       (flush_front),
    .ex_busy_rd_i  (ex_busy_rd),
    .ex_busy_i     (ex_busy),
    .cm_busy_rd_i  (cm_busy_rd),
    .cm_busy_i     (cm_busy),
    .rf_we_i       (rf_we),
    .rf_waddr_i    (rf_waddr),
    .rf_wdata_i    (rf_wdata),
    .stall_o       (stall),
    .decoded_o     (decoded)
  );

  execute_stage u_execute (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .decoded_i         (decoded),
    .flush_i           (flush_ex),
    .busy_rd_o         (ex_busy_rd),
    .busy_o            (ex_busy),
    .branch_redirect_o (branch_redirect),
    .result_o          (exec_result)
  );

  commit_stage u_commit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .result_i        (exec_result),
    .count_value_i   (count_value),
    .csr_addr_o      (csr_addr),
    .retire_o        (retire),
    .br_taken_o      (br_taken),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .busy_rd_o       (cm_busy_rd),
    .busy_o          (cm_busy),
    .trap_redirect_o (trap_redirect),
    .commit_trace_o  (commit_trace_o)
  );

  pipeline_ctrl u_ctrl (
    .branch_redirect_i (branch_redirect),
    .trap_redirect_i   (trap_redirect),
    .redirect_o        (redirect),
    .flush_front_o     (flush_front),
    .flush_ex_o        (flush_ex)
  );

  perf_counters u_perf (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .retire_i      (retire),
    .br_taken_i    (br_taken),
    .csr_addr_i    (csr_addr),
    .count_value_o (count_value)
  );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/core_tb.sv
`default_nettype none

`include "core_cfg.svh"

module core_tb;

  localparam int IMEM_WORDS        = 128;
  localparam int INPUT_WORDS       = 256;
  localparam int HEADER_WORDS      = 3;
  localparam int RECORD_WORDS      = 5;
  localparam int CYCLES_PER_RECORD = 20;
  localparam int RESET_CYCLES      = 2;
  localparam logic [`CORE_XLEN-1:0] NOP_WORD = 32'h0000_0013;

  logic                    clk;
  logic                    rst_n;
  logic [`CORE_XLEN-1:0]   imem_addr;
  logic [`CORE_XLEN-1:0]   imem_rdata;
  core_pkg::commit_trace_t commit_trace;

  logic [31:0]             input_mem [0:INPUT_WORDS-1];
  logic [`CORE_XLEN-1:0]   imem [0:IMEM_WORDS-1];
  core_pkg::commit_trace_t expected [$];
  int                      main_len;
  int                      handler_len;
  int                      n_records;
  int                      rec_idx;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tiny_core u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .commit_trace_o (commit_trace)
  );

  // Same-cycle instruction read with NOP outside the modeled range
  assign imem_rdata = (imem_addr < IMEM_WORDS * 4) ? imem[imem_addr[8:2]] : NOP_WORD;

  // ----------------------------------------------------------
  // Input file and reporting
  // ----------------------------------------------------------
  task automatic load_input();
    int                      base;
    core_pkg::commit_trace_t rec;
    $readmemh("test/core_input.hex", input_mem);
    if ($isunknown({input_mem[0], input_mem[1], input_mem[2]})) begin
      $display("Input file test/core_input.hex is missing or has no header");
      $display("Checks failed");
      $fatal(1, "Cannot load stimulus");
    end else begin
      main_len    = input_mem[0];
      handler_len = input_mem[1];
      n_records   = input_mem[2];
      for (int a = 0; a < IMEM_WORDS; a++) begin
        imem[a] = NOP_WORD;
      end
      for (int a = 0; a < main_len; a++) begin
        imem[a] = input_mem[HEADER_WORDS + a];
      end
      // Trap handler sits at the trap vector
      for (int a = 0; a < handler_len; a++) begin
        imem[(`CORE_TRAP_VECTOR >> 2) + a] = input_mem[HEADER_WORDS + main_len + a];
      end
      base = HEADER_WORDS + main_len + handler_len;
      for (int r = 0; r < n_records; r++) begin
        rec.valid     = 1'b1;
        rec.pc        = input_mem[base + r * RECORD_WORDS];
        rec.rd        = input_mem[base + r * RECORD_WORDS + 1][4:0];
        rec.wdata     = input_mem[base + r * RECORD_WORDS + 2];
        rec.exception = input_mem[base + r * RECORD_WORDS + 3][0];
        rec.tval      = input_mem[base + r * RECORD_WORDS + 4];
        expected.push_back(rec);
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [`CORE_XLEN-1:0] got,
                                 input logic [`CORE_XLEN-1:0] exp);
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    $display("Checks failed");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic compare_trace(input int idx, input core_pkg::commit_trace_t got,
                               input core_pkg::commit_trace_t exp);
    if (got.pc !== exp.pc) begin
      report_mismatch($sformatf("commit_trace_o.pc (record %0d)", idx), got.pc, exp.pc);
    end
    if (got.rd !== exp.rd) begin
      report_mismatch($sformatf("commit_trace_o.rd (record %0d)", idx), got.rd, exp.rd);
    end
    if (got.wdata !== exp.wdata) begin
      report_mismatch($sformatf("commit_trace_o.wdata (record %0d)", idx), got.wdata,
                      exp.wdata);
    end
    if (got.exception !== exp.exception) begin
      report_mismatch($sformatf("commit_trace_o.exception (record %0d)", idx),
                      got.exception, exp.exception);
    end
    if (got.tval !== exp.tval) begin
      report_mismatch($sformatf("commit_trace_o.tval (record %0d)", idx), got.tval, exp.tval);
    end
  endtask

  task automatic compare_word(input string name, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Trace checking with a reference count of retirements
  // ----------------------------------------------------------
  initial begin : run_checks
    core_pkg::commit_trace_t got;
    isa_pkg::instr_t         word;
    logic [`CORE_XLEN-1:0]   instret_model;
    logic [`CORE_XLEN-1:0]   taken_model;
    logic [`CORE_XLEN-1:0]   prev_pc;
    logic                    prev_branch;
    instret_model = '0;
    taken_model   = '0;
    prev_pc       = '0;
    prev_branch   = 1'b0;
    rec_idx       = 0;
    load_input();
    // In reset the PC sits at the boot address and nothing retires
    @(negedge clk);
    compare_word("imem_addr_o during reset", imem_addr, `CORE_BOOT_ADDR);
    compare_word("commit_trace_o.valid during reset", commit_trace.valid, '0);
    @(posedge rst_n);
    while (rec_idx < n_records) begin
      // Trace settles after the rising edge
      @(negedge clk);
      got = commit_trace;
      if (got.valid === 1'b1) begin
        word = (got.pc < IMEM_WORDS * 4) ? imem[got.pc[8:2]] : NOP_WORD;
        if (prev_branch && got.pc != prev_pc + 32'd4) begin
          taken_model = taken_model + 1'b1;
        end
        compare_trace(rec_idx, got, expected[rec_idx]);
        if (word.i.opcode == isa_pkg::OPC_SYSTEM && word.i.funct3 == isa_pkg::F3_CSRRS) begin
          if (word.i.imm == `CORE_CSR_INSTRET) begin
            compare_word("instret read wdata", got.wdata, instret_model);
          end else if (word.i.imm == `CORE_CSR_BRTAKEN) begin
            compare_word("taken-branch read wdata", got.wdata, taken_model);
          end
        end
        if (!got.exception) begin
          instret_model = instret_model + 1'b1;
        end
        prev_pc     = got.pc;
        prev_branch = (word.b.opcode == isa_pkg::OPC_BRANCH);
        rec_idx++;
      end
    end
    $display("All checks passed");
    $finish;
  end

  initial begin : watchdog
    #1;
    repeat (n_records * CYCLES_PER_RECORD + RESET_CYCLES) @(posedge clk);
    $display("Commit stream stalled with %0d of %0d records seen", rec_idx, n_records);
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: test/core_input.hex
// Header: main program words, trap handler words, expected records
// Then program at 0x0, handler at 0x100, records as: pc rd wdata exception tval
0f 02 10
// Main program
123450b7 // lui   x1, 0x12345
67808093 // addi  x1, x1, 0x678
fff00113 // addi  x2, x0, -1
0020c1b3 // xor   x3, x1, x2
40118233 // sub   x4, x3, x1
0f026293 // ori   x5, x4, 0x0f0
7ff0f313 // andi  x6, x1, 0x7ff
0550e013 // ori   x0, x1, 0x055
000083b3 // add   x7, x1, x0
00208463 // beq   x1, x2, +8 (not taken)
00209463 // bne   x1, x2, +8 (taken)
09900493 // addi  x9, x0, 0x099 (skipped)
b0202573 // csrrs x10, instret, x0
b03025f3 // csrrs x11, brtaken, x0
deadbeef // unsupported opcode
// Trap handler
b02026f3 // csrrs x13, instret, x0
b0302773 // csrrs x14, brtaken, x0
// Expected commit records
00000000 01 12345000 0 00000000
00000004 01 12345678 0 00000000
00000008 02 ffffffff 0 00000000
0000000c 03 edcba987 0 00000000
00000010 04 db97530f 0 00000000
00000014 05 db9753ff 0 00000000
00000018 06 00000678 0 00000000
0000001c 00 00000000 0 00000000
00000020 07 12345678 0 00000000
00000024 00 00000000 0 00000000
00000028 00 00000000 0 00000000
00000030 0a 0000000b 0 00000000
00000034 0b 00000001 0 00000000
00000038 00 00000000 1 deadbeef
00000100 0d 0000000d 0 00000000
00000104 0e 00000001 0 00000000

// File: verilog.f
+incdir+include
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/commit_stage.sv
hw/pipeline_ctrl.sv
hw/perf_counters.sv
hw/tiny_core.sv
test/tb_clock_gen.sv
test/core_tb.sv
